/* Makefile */
# Verilator simulation of the FP8 dot-product unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_tcu_fp8_dot -Mdir obj_dir -f project.f

run: compile
	./obj_dir/Vtb_tcu_fp8_dot > sim.log 2>&1; cat sim.log
	grep -q -x -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
rtl/tcu_pkg.sv
rtl/fp8_classifier.sv
rtl/fp8_pair_mul.sv
rtl/dot_accum.sv
rtl/dot_ctrl.sv
rtl/tcu_fp8_dot.sv
tests/tb_clock.sv
tests/tb_tcu_fp8_dot.sv

/* rtl/dot_accum.sv */
// --------------------------------------
// Dot-product accumulator
// Stage 1 lane registers, stage 2 fixed
// point sum and sticky exception flags
// --------------------------------------
`timescale 1ns/10ps

module dot_accum (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         step_en,
    input  logic                                         acc_clear,
    input  tcu_pkg::lane_sig_t [tcu_pkg::N_LANES-1:0]    lane_sig,
    input  tcu_pkg::exp_sum_t  [tcu_pkg::N_LANES-1:0]    lane_exp,
    input  tcu_pkg::excep_t    [tcu_pkg::N_LANES-1:0]    lane_exc,
    output tcu_pkg::acc_t                                result,
    output tcu_pkg::excep_t                              exc
);
    logic                                      s1_valid;
    tcu_pkg::lane_sig_t [tcu_pkg::N_LANES-1:0] s1_sig;
    tcu_pkg::exp_sum_t  [tcu_pkg::N_LANES-1:0] s1_exp;
    tcu_pkg::excep_t    [tcu_pkg::N_LANES-1:0] s1_exc;
    tcu_pkg::acc_t                             step_sum;
    tcu_pkg::acc_t                             sum_q;
    logic                                      step_nan, step_pos, step_neg;
    logic                                      nan_q, pos_inf_q, neg_inf_q;
    logic                                      nan_out;

    // Lane magnitude scaled by its exponent sum, sign applied
    function automatic tcu_pkg::acc_t lane_value(input tcu_pkg::lane_sig_t sig,
                                                 input tcu_pkg::exp_sum_t  e);
        tcu_pkg::acc_t mag;
        mag = tcu_pkg::acc_t'(sig[23:0]) << e;
        return sig[24] ? -mag : mag;
    endfunction

    // --------------------------------------
    // Stage 1
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= step_en;
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            s1_sig <= lane_sig;
            s1_exp <= lane_exp;
            s1_exc <= lane_exc;
        end
    end

    // Sum of the four lanes and the step's flags
    always_comb begin
        step_sum = '0;
        step_nan = 1'b0;
        step_pos = 1'b0;
        step_neg = 1'b0;
        for (int i = 0; i < tcu_pkg::N_LANES; i++) begin
            step_sum = step_sum + lane_value(s1_sig[i], s1_exp[i]);
            step_nan = step_nan | s1_exc[i][tcu_pkg::EXC_NAN];
            step_pos = step_pos | (s1_exc[i][tcu_pkg::EXC_INF] & ~s1_exc[i][tcu_pkg::EXC_SIGN]);
            step_neg = step_neg | (s1_exc[i][tcu_pkg::EXC_INF] & s1_exc[i][tcu_pkg::EXC_SIGN]);
        end
    end

    // --------------------------------------
    // Stage 2
    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            sum_q     <= '0;
            nan_q     <= 1'b0;
            pos_inf_q <= 1'b0;
            neg_inf_q <= 1'b0;
        end else if (s1_valid) begin
            sum_q     <= sum_q + step_sum;
            nan_q     <= nan_q | step_nan;
            pos_inf_q <= pos_inf_q | step_pos;
            neg_inf_q <= neg_inf_q | step_neg;
        end
    end

    // Infinities of both signs over the run make NaN
    assign nan_out = nan_q | (pos_inf_q & neg_inf_q);

    always_comb begin
        exc                    = '0;
        exc[tcu_pkg::EXC_NAN]  = nan_out;
        exc[tcu_pkg::EXC_INF]  = (pos_inf_q | neg_inf_q) & ~nan_out;
        exc[tcu_pkg::EXC_SIGN] = neg_inf_q & ~nan_out;
    end

    assign result = sum_q;

endmodule

/* rtl/dot_ctrl.sv */
// --------------------------------------
// Run controller
// Start handling, step counting, drain
// wait, busy and done
// --------------------------------------
`timescale 1ns/10ps

module dot_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               step_valid,
    input  logic               fmt,
    input  tcu_pkg::step_cnt_t num_steps,
    output logic               fmt_q,
    output logic               step_en,
    output logic               acc_clear,
    output logic               busy,
    output logic               done
);
    tcu_pkg::ctrl_state_t state;
    tcu_pkg::step_cnt_t   target;
    tcu_pkg::step_cnt_t   count;
    logic                 last_step;

    // Start is ignored while a run is going
    assign acc_clear = start && (state == tcu_pkg::ST_IDLE);
    // Steps only accepted in ST_RUN, which ends on the final one
    assign step_en   = step_valid && (state == tcu_pkg::ST_RUN);
    assign last_step = step_en && (tcu_pkg::step_cnt_t'(count + 1'b1) == target);
    assign busy      = (state != tcu_pkg::ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= tcu_pkg::ST_IDLE;
            fmt_q  <= tcu_pkg::FMT_E4M3;
            target <= '0;
            count  <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                tcu_pkg::ST_IDLE: begin
                    if (start) begin
                        fmt_q <= fmt;
                        // Zero encodes a full run of 16
                        target <= (num_steps == '0) ? tcu_pkg::step_cnt_t'(16) : num_steps;
                        count <= '0;
                        state <= tcu_pkg::ST_RUN;
                    end
                end
                tcu_pkg::ST_RUN: begin
                    if (step_en) begin
                        count <= count + 1'b1;
                    end
                    if (last_step) begin
                        state <= tcu_pkg::ST_DRAIN;
                    end
                end
                tcu_pkg::ST_DRAIN: begin
                    // Last step reaches the sum on this edge
                    state <= tcu_pkg::ST_IDLE;
                    done  <= 1'b1;
                end
                default: begin
                    state <= tcu_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/fp8_classifier.sv */
// --------------------------------------
// FP8 element classifier
// Zero, subnormal, infinity and NaN flags
// for E4M3 and E5M2
// --------------------------------------
`timescale 1ns/10ps

module fp8_classifier (
    input  tcu_pkg::fp8_t elem,
    input  logic          fmt,
    output logic          is_zero,
    output logic          is_sub,
    output logic          is_inf,
    output logic          is_nan
);
    logic       is_e5m2;
    logic [4:0] exp_field;
    logic [2:0] man_field;

    assign is_e5m2 = (fmt == tcu_pkg::FMT_E5M2);

    // E5M2 keeps a 2-bit mantissa, padded to three bits
    assign exp_field = is_e5m2 ? elem[6:2] : {1'b0, elem[6:3]};
    assign man_field = is_e5m2 ? {elem[1:0], 1'b0} : elem[2:0];

    assign is_zero = (exp_field == 5'd0) && (man_field == 3'd0);
    assign is_sub  = (exp_field == 5'd0) && (man_field != 3'd0);

    // Only E5M2 has infinity; E4M3 spends its top code on NaN
    assign is_inf = is_e5m2 && (exp_field == 5'h1f) && (man_field == 3'd0);
    assign is_nan = is_e5m2 ? ((exp_field == 5'h1f) && (man_field != 3'd0))
                            : ((exp_field == 5'h0f) && (man_field == 3'b111));

endmodule

/* rtl/fp8_pair_mul.sv */
// --------------------------------------
// One dot-product lane
// Two FP8 products, aligned in a 24-bit
// frame, summed and halved, plus merged
// exception flags
// --------------------------------------
`timescale 1ns/10ps

module fp8_pair_mul (
    input  logic [15:0]        a_pair,
    input  logic [15:0]        b_pair,
    input  logic [1:0]         mask,
    input  logic               fmt,
    output tcu_pkg::lane_sig_t lane_sig,
    output tcu_pkg::exp_sum_t  lane_exp,
    output tcu_pkg::excep_t    lane_exc
);
    logic                is_e5m2;
    tcu_pkg::exp_sum_t   exp_sum [2];
    logic [7:0]          prod    [2];
    logic [1:0]          prod_sign;
    logic [1:0]          counted;
    logic [1:0]          nan_p;
    logic [1:0]          inf_p;

    assign is_e5m2 = (fmt == tcu_pkg::FMT_E5M2);

    // --------------------------------------
    // Per product decode and multiply
    for (genvar j = 0; j < 2; j++) begin : g_prod
        tcu_pkg::fp8_t a_el;
        tcu_pkg::fp8_t b_el;
        logic          a_zero, a_sub, a_inf, a_nan;
        logic          b_zero, b_sub, b_inf, b_nan;
        logic [4:0]    a_exp, b_exp;
        logic [3:0]    a_man, b_man;
        logic          inf_zero;

        assign a_el = a_pair[8*j +: 8];
        assign b_el = b_pair[8*j +: 8];

        fp8_classifier u_cls_a (
            .elem    (a_el),
            .fmt     (fmt),
            .is_zero (a_zero),
            .is_sub  (a_sub),
            .is_inf  (a_inf),
            .is_nan  (a_nan)
        );

        fp8_classifier u_cls_b (
            .elem    (b_el),
            .fmt     (fmt),
            .is_zero (b_zero),
            .is_sub  (b_sub),
            .is_inf  (b_inf),
            .is_nan  (b_nan)
        );

        // Subnormals sit at exponent 1
        assign a_exp = a_sub ? 5'd1 : (is_e5m2 ? a_el[6:2] : {1'b0, a_el[6:3]});
        assign b_exp = b_sub ? 5'd1 : (is_e5m2 ? b_el[6:2] : {1'b0, b_el[6:3]});

        // Implicit one only for normal numbers
        assign a_man = {~(a_sub | a_zero), is_e5m2 ? {a_el[1:0], 1'b0} : a_el[2:0]};
        assign b_man = {~(b_sub | b_zero), is_e5m2 ? {b_el[1:0], 1'b0} : b_el[2:0]};

        assign exp_sum[j]   = tcu_pkg::exp_sum_t'(a_exp) + tcu_pkg::exp_sum_t'(b_exp);
        assign prod[j]      = a_man * b_man;
        assign prod_sign[j] = a_el[7] ^ b_el[7];
        assign counted[j]   = mask[j] & ~a_zero & ~b_zero;

        // inf * 0 is invalid
        assign inf_zero = (a_inf & b_zero) | (a_zero & b_inf);
        assign nan_p[j] = mask[j] & (a_nan | b_nan | inf_zero);
        assign inf_p[j] = mask[j] & (a_inf | b_inf) & ~inf_zero;
    end

    // --------------------------------------
    // Alignment to the larger exponent sum
    logic              t0_max;
    tcu_pkg::exp_sum_t max_sum;
    tcu_pkg::exp_sum_t min_sum;
    tcu_pkg::exp_sum_t diff;
    logic [23:0]       frame0, frame1;
    logic [23:0]       al0, al1;

    // An uncounted product never wins the max
    assign t0_max  = counted[0] & (~counted[1] | (exp_sum[0] >= exp_sum[1]));
    assign max_sum = t0_max ? exp_sum[0] : exp_sum[1];
    assign min_sum = t0_max ? exp_sum[1] : exp_sum[0];
    assign diff    = max_sum - min_sum;

    // Product at the top of the frame
    assign frame0 = counted[0] ? {prod[0], 16'b0} : 24'b0;
    assign frame1 = counted[1] ? {prod[1], 16'b0} : 24'b0;

    // Bits shifted below the frame are lost
    assign al0 = t0_max ? frame0 : (diff[5] ? 24'b0 : (frame0 >> diff[4:0]));
    assign al1 = t0_max ? (diff[5] ? 24'b0 : (frame1 >> diff[4:0])) : frame1;

    // --------------------------------------
    // Signed magnitude add
    logic [24:0] mag0, mag1;
    logic [24:0] op_a, op_b;
    logic [24:0] sum_raw;
    logic        mag0_larger;
    logic        do_sub;
    logic        cancel;
    logic        sig_sign;

    assign mag0        = {1'b0, al0};
    assign mag1        = {1'b0, al1};
    assign mag0_larger = (mag0 > mag1);
    assign op_a        = mag0_larger ? mag0 : mag1;
    assign op_b        = mag0_larger ? mag1 : mag0;
    assign do_sub      = prod_sign[0] ^ prod_sign[1];
    assign sum_raw     = do_sub ? (op_a - op_b) : (op_a + op_b);

    // Exact cancellation or nothing counted gives +0
    assign cancel   = (sum_raw == 25'd0);
    assign sig_sign = ~cancel & (mag0_larger ? prod_sign[0] : prod_sign[1]);

    // Halved so the sum fits 24 bits without renormalizing
    assign lane_sig = {sig_sign, sum_raw[24:1]};
    assign lane_exp = ((|counted) && !cancel) ? max_sum : '0;

    // --------------------------------------
    // Exception merge
    logic add_nan;
    logic any_nan;
    logic any_inf;

    // +inf plus -inf inside the lane
    assign add_nan = inf_p[0] & inf_p[1] & do_sub;
    assign any_nan = (|nan_p) | add_nan;
    assign any_inf = (|inf_p) & ~any_nan;

    always_comb begin
        lane_exc                    = '0;
        lane_exc[tcu_pkg::EXC_NAN]  = any_nan;
        lane_exc[tcu_pkg::EXC_INF]  = any_inf;
        lane_exc[tcu_pkg::EXC_SIGN] = any_inf & (inf_p[0] ? prod_sign[0] : prod_sign[1]);
    end

endmodule

/* rtl/tcu_fp8_dot.sv */
// --------------------------------------
// FP8 dot-product unit, top level
// Controller, four lanes, accumulator
// --------------------------------------
`timescale 1ns/10ps

module tcu_fp8_dot (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          fmt,
    input  tcu_pkg::step_cnt_t            num_steps,
    input  logic                          step_valid,
    input  tcu_pkg::elem_vec_t            a_data,
    input  tcu_pkg::elem_vec_t            b_data,
    input  logic [tcu_pkg::N_ELEMS-1:0]   elem_mask,
    output tcu_pkg::acc_t                 result,
    output tcu_pkg::excep_t               exc,
    output logic                          busy,
    output logic                          done
);
    logic                                      fmt_q;
    logic                                      step_en;
    logic                                      acc_clear;
    tcu_pkg::lane_sig_t [tcu_pkg::N_LANES-1:0] lane_sig;
    tcu_pkg::exp_sum_t  [tcu_pkg::N_LANES-1:0] lane_exp;
    tcu_pkg::excep_t    [tcu_pkg::N_LANES-1:0] lane_exc;

    dot_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .step_valid (step_valid),
        .fmt        (fmt),
        .num_steps  (num_steps),
        .fmt_q      (fmt_q),
        .step_en    (step_en),
        .acc_clear  (acc_clear),
        .busy       (busy),
        .done       (done)
    );

    // Lane i takes elements 2i and 2i+1
    for (genvar i = 0; i < tcu_pkg::N_LANES; i++) begin : g_lane
        fp8_pair_mul u_mul (
            .a_pair   (a_data[16*i +: 16]),
            .b_pair   (b_data[16*i +: 16]),
            .mask     (elem_mask[2*i +: 2]),
            .fmt      (fmt_q),
            .lane_sig (lane_sig[i]),
            .lane_exp (lane_exp[i]),
            .lane_exc (lane_exc[i])
        );
    end

    dot_accum u_accum (
        .clk       (clk),
        .reset     (reset),
        .step_en   (step_en),
        .acc_clear (acc_clear),
        .lane_sig  (lane_sig),
        .lane_exp  (lane_exp),
        .lane_exc  (lane_exc),
        .result    (result),
        .exc       (exc)
    );

endmodule

/* rtl/tcu_pkg.sv */
// --------------------------------------
// Shared definitions for the FP8 dot unit
// Sizes, format codes, vector types,
// exception bit positions, controller states
// --------------------------------------

package tcu_pkg;

    // --------------------------------------
    // Sizes
    localparam int N_LANES = 4;
    localparam int N_ELEMS = 8;
    localparam int ACC_W   = 96;
    localparam int STEP_W  = 5;

    // Format bit values
    localparam logic FMT_E4M3 = 1'b0;
    localparam logic FMT_E5M2 = 1'b1;

    // Exception bit positions inside excep_t
    localparam int EXC_NAN  = 2;
    localparam int EXC_INF  = 1;
    localparam int EXC_SIGN = 0;

    // --------------------------------------
    typedef logic [7:0]             fp8_t;
    // Element k sits at bits [8k+7:8k]
    typedef logic [N_ELEMS*8-1:0]   elem_vec_t;
    // Sign on bit 24, magnitude below
    typedef logic [24:0]            lane_sig_t;
    typedef logic [5:0]             exp_sum_t;
    typedef logic [ACC_W-1:0]       acc_t;
    typedef logic [2:0]             excep_t;
    typedef logic [STEP_W-1:0]      step_cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } ctrl_state_t;

endpackage

/* tests/tb_clock.sv */
// --------------------------------------
// Testbench clock generator
// 40 ns period, starts low
// --------------------------------------
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);
    localparam real HALF_PERIOD = 20.0;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD);
        clk = ~clk;
    end

endmodule

/* tests/tb_tcu_fp8_dot.sv */
// --------------------------------------
// Testbench for the FP8 dot-product unit
// Run table, reference model of the lane
// and value rules, checks and report
// --------------------------------------
`timescale 1ns/10ps

module tb_tcu_fp8_dot;

    localparam int MAX_STEPS = 64;
    localparam int MAX_RUNS  = 16;
    localparam int TIMEOUT   = 50;

    logic                        clk;
    logic                        reset;
    logic                        start;
    logic                        fmt;
    tcu_pkg::step_cnt_t          num_steps;
    logic                        step_valid;
    tcu_pkg::elem_vec_t          a_data;
    tcu_pkg::elem_vec_t          b_data;
    logic [tcu_pkg::N_ELEMS-1:0] elem_mask;
    tcu_pkg::acc_t               result;
    tcu_pkg::excep_t             exc;
    logic                        busy;
    logic                        done;

    // --------------------------------------
    // Stimulus table, steps and runs
    tcu_pkg::elem_vec_t          step_a [MAX_STEPS];
    tcu_pkg::elem_vec_t          step_b [MAX_STEPS];
    logic [tcu_pkg::N_ELEMS-1:0] step_m [MAX_STEPS];
    string                       run_name   [MAX_RUNS];
    logic                        run_fmt    [MAX_RUNS];
    int                          run_first  [MAX_RUNS];
    int                          run_len    [MAX_RUNS];
    logic                        run_poke   [MAX_RUNS];
    logic                        run_lit_on [MAX_RUNS];
    tcu_pkg::acc_t               run_lit    [MAX_RUNS];
    int                          n_steps;
    int                          n_runs;
    logic [31:0]                 rng;
    int                          errors;
    int                          tests_failed;

    tb_clock u_clk (
        .clk (clk)
    );

    tcu_fp8_dot u_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fmt        (fmt),
        .num_steps  (num_steps),
        .step_valid (step_valid),
        .a_data     (a_data),
        .b_data     (b_data),
        .elem_mask  (elem_mask),
        .result     (result),
        .exc        (exc),
        .busy       (busy),
        .done       (done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Top exponent code of E5M2 is kept out of random data
    function automatic tcu_pkg::elem_vec_t finite_e5m2(input tcu_pkg::elem_vec_t v);
        tcu_pkg::elem_vec_t r;
        r = v;
        for (int k = 0; k < tcu_pkg::N_ELEMS; k++) begin
            if (r[8*k+2 +: 5] == 5'h1f) begin
                r[8*k+6] = 1'b0;
            end
        end
        return r;
    endfunction

    // Exponent field and 3-bit mantissa field of one element
    function automatic int exp_of(input logic f, input tcu_pkg::fp8_t x);
        return f ? int'(x[6:2]) : int'(x[6:3]);
    endfunction

    function automatic int man_of(input logic f, input tcu_pkg::fp8_t x);
        return f ? int'({x[1:0], 1'b0}) : int'(x[2:0]);
    endfunction

    function automatic logic is_nan(input logic f, input tcu_pkg::fp8_t x);
        if (f) begin
            return (x[6:2] == 5'h1f) && (x[1:0] != 2'b00);
        end else begin
            return x[6:0] == 7'h7f;
        end
    endfunction

    // --------------------------------------
    // Reference model of one step
    task automatic model_step(input logic f, input tcu_pkg::elem_vec_t a,
                              input tcu_pkg::elem_vec_t b, input logic [7:0] m,
                              inout tcu_pkg::acc_t sum, inout logic any_nan,
                              inout logic seen_pos, inout logic seen_neg);
        tcu_pkg::fp8_t x, y;
        int            ex, ey, mx, my, maxe, sh;
        longint        prod [2];
        int            esum [2];
        logic          neg_p [2];
        logic          used [2];
        logic          x_inf, y_inf, x_zero, y_zero;
        longint        frame, tot;
        tcu_pkg::acc_t mag;
        for (int l = 0; l < tcu_pkg::N_LANES; l++) begin
            maxe = 0;
            for (int j = 0; j < 2; j++) begin
                x = a[16*l+8*j +: 8];
                y = b[16*l+8*j +: 8];
                ex = exp_of(f, x);
                ey = exp_of(f, y);
                mx = man_of(f, x);
                my = man_of(f, y);
                x_zero = (ex == 0) && (mx == 0);
                y_zero = (ey == 0) && (my == 0);
                x_inf = f && (ex == 31) && (mx == 0);
                y_inf = f && (ey == 31) && (my == 0);
                neg_p[j] = x[7] ^ y[7];
                if (m[2*l+j]) begin
                    if (is_nan(f, x) || is_nan(f, y) || (x_inf && y_zero) || (x_zero && y_inf)) begin
                        any_nan = 1'b1;
                    end else if (x_inf || y_inf) begin
                        seen_neg = seen_neg | neg_p[j];
                        seen_pos = seen_pos | ~neg_p[j];
                    end
                end
                // Subnormals take exponent 1 and no hidden one
                prod[j] = longint'((ex == 0) ? mx : mx + 8) * longint'((ey == 0) ? my : my + 8);
                esum[j] = ((ex == 0) ? 1 : ex) + ((ey == 0) ? 1 : ey);
                used[j] = m[2*l+j] && !x_zero && !y_zero;
                if (used[j] && esum[j] > maxe) begin
                    maxe = esum[j];
                end
            end
            tot = 0;
            for (int j = 0; j < 2; j++) begin
                if (used[j]) begin
                    sh = maxe - esum[j];
                    if (sh >= 32) begin
                        frame = 0;
                    end else begin
                        frame = (prod[j] << 16) >> sh;
                    end
                    tot = neg_p[j] ? tot - frame : tot + frame;
                end
            end
            // Halved magnitude, weighted by the larger exponent sum
            mag = tcu_pkg::acc_t'((tot < 0) ? -tot : tot) >> 1;
            mag = mag << maxe;
            sum = (tot < 0) ? sum - mag : sum + mag;
        end
    endtask

    task automatic check_value(input string name, input tcu_pkg::acc_t got,
                               input tcu_pkg::acc_t want);
        assert (got == want) else begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic add_step(input tcu_pkg::elem_vec_t a, input tcu_pkg::elem_vec_t b,
                            input logic [7:0] m);
        step_a[n_steps] = a;
        step_b[n_steps] = b;
        step_m[n_steps] = m;
        n_steps++;
    endtask

    // Steps of a run are added just before the run itself
    task automatic add_run(input string name, input logic f, input int len, input logic poke,
                           input logic lit_on, input tcu_pkg::acc_t lit);
        run_name[n_runs]   = name;
        run_fmt[n_runs]    = f;
        run_first[n_runs]  = n_steps - len;
        run_len[n_runs]    = len;
        run_poke[n_runs]   = poke;
        run_lit_on[n_runs] = lit_on;
        run_lit[n_runs]    = lit;
        n_runs++;
    endtask

    // --------------------------------------
    task automatic build_table();
        tcu_pkg::elem_vec_t ra, rb;
        // One step of normal numbers with a dot product of 11.5
        add_step(64'h3AB8_4430_B040_3C38, 64'h4038_3840_403C_4038, 8'hff);
        add_run("e4m3 single step", tcu_pkg::FMT_E4M3, 1, 1'b0, 1'b1, tcu_pkg::acc_t'(23) << 34);
        for (int s = 0; s < 16; s++) begin
            rng = xorshift(rng);
            ra[63:32] = rng;
            rng = xorshift(rng);
            ra[31:0] = rng;
            rng = xorshift(rng);
            rb[63:32] = rng;
            rng = xorshift(rng);
            rb[31:0] = rng;
            add_step(finite_e5m2(ra), finite_e5m2(rb), 8'hff);
        end
        add_run("e5m2 random 16 steps", tcu_pkg::FMT_E5M2, 16, 1'b0, 1'b0, '0);
        // Partial mask, full mask with hidden NaNs, then subnormals
        add_step(64'h3C40_B838_4438_3A30, 64'h3838_4040_3C38_3840, 8'ha6);
        add_step(64'h7F7F_4444_3838_4040, 64'h3838_3838_3838_3838, 8'h00);
        add_step(64'h0305_8501_3802_0307, 64'h3840_3838_0330_4838, 8'hff);
        add_run("masks and subnormals", tcu_pkg::FMT_E4M3, 3, 1'b0, 1'b0, '0);
        // Every lane cancels, then eight times 1.25
        add_step(64'h3838_3838_4040_3C3C, 64'hB838_38B8_C040_BC3C, 8'hff);
        add_step(64'h3A3A_3A3A_3A3A_3A3A, 64'h3838_3838_3838_3838, 8'hff);
        add_run("cancel and clear", tcu_pkg::FMT_E4M3, 2, 1'b0, 1'b1, tcu_pkg::acc_t'(10) << 35);
        add_step(64'h3838_3838_3838_387F, 64'h3838_3838_3838_3838, 8'hff);
        add_run("e4m3 nan operand", tcu_pkg::FMT_E4M3, 1, 1'b0, 1'b0, '0);
        add_step(64'h3C3C_3C3C_3C3C_3C7C, 64'h3C3C_3C3C_3C3C_3C00, 8'hff);
        add_run("inf times zero", tcu_pkg::FMT_E5M2, 1, 1'b0, 1'b0, '0);
        add_step(64'h3C3C_3C3C_3C3C_3C7C, 64'h3C3C_3C3C_3C3C_3C3C, 8'hff);
        add_step(64'h3C3C_3C3C_3CFC_3C3C, 64'h3C3C_3C3C_3C3C_3C3C, 8'hff);
        add_run("opposite infinities", tcu_pkg::FMT_E5M2, 2, 1'b0, 1'b0, '0);
        add_step(64'h3C3C_FC3C_7C3C_3CFC, 64'h3C3C_3C3C_BC3C_3C3C, 8'hff);
        add_run("negative infinity", tcu_pkg::FMT_E5M2, 1, 1'b0, 1'b0, '0);
        add_step(64'h3C3C_3C3C_3C7C_3C3C, 64'h3C3C_3C3C_3C3C_3C3C, 8'hff);
        add_run("positive infinity", tcu_pkg::FMT_E5M2, 1, 1'b0, 1'b0, '0);
        // 0x7E is a finite E4M3 value
        add_step(64'h387E_3838_4040_3C3C, 64'h3838_B838_3838_4038, 8'hff);
        add_step(64'h3A3A_3A3A_3A3A_3A3A, 64'h3838_3838_3838_3838, 8'h0f);
        add_step(64'h4444_3C3C_3A38_4038, 64'h3838_4040_3838_3C3C, 8'hf0);
        add_run("ignored start and step", tcu_pkg::FMT_E4M3, 3, 1'b1, 1'b0, '0);
    endtask

    // --------------------------------------
    task automatic run_test(input int r);
        tcu_pkg::acc_t   want_sum;
        tcu_pkg::excep_t want_exc;
        logic            any_nan, seen_pos, seen_neg, nan_f;
        int              cycles;
        int              idx;
        int              err_before;
        err_before = errors;
        want_sum = '0;
        any_nan = 1'b0;
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        for (int s = 0; s < run_len[r]; s++) begin
            idx = run_first[r] + s;
            model_step(run_fmt[r], step_a[idx], step_b[idx], step_m[idx],
                       want_sum, any_nan, seen_pos, seen_neg);
        end
        // Sticky flags over the run
        nan_f = any_nan | (seen_pos & seen_neg);
        want_exc = '0;
        want_exc[tcu_pkg::EXC_NAN]  = nan_f;
        want_exc[tcu_pkg::EXC_INF]  = (seen_pos | seen_neg) & ~nan_f;
        want_exc[tcu_pkg::EXC_SIGN] = seen_neg & ~nan_f;

        @(negedge clk);
        start = 1'b1;
        fmt = run_fmt[r];
        num_steps = tcu_pkg::step_cnt_t'(run_len[r] % 16);
        @(negedge clk);
        start = 1'b0;
        check_value("busy", tcu_pkg::acc_t'(busy), 1);
        for (int s = 0; s < run_len[r]; s++) begin
            if (s > 0) begin
                @(negedge clk);
                start = 1'b0;
            end
            idx = run_first[r] + s;
            step_valid = 1'b1;
            a_data = step_a[idx];
            b_data = step_b[idx];
            elem_mask = step_m[idx];
            // Second start with other settings while the run is busy
            if (run_poke[r] && s == 1) begin
                start = 1'b1;
                fmt = ~run_fmt[r];
                num_steps = 5'd5;
            end
        end
        @(negedge clk);
        start = 1'b0;
        // Extra step after the count is reached
        step_valid = run_poke[r];
        cycles = 1;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            step_valid = 1'b0;
            cycles++;
        end
        assert (done) else begin
            $display("Test %0d: done never came within %0d cycles", r, TIMEOUT);
            errors++;
        end
        check_value("done latency", tcu_pkg::acc_t'(cycles), 2);
        check_value("busy", tcu_pkg::acc_t'(busy), 0);
        check_value("result", result, want_sum);
        if (run_lit_on[r]) begin
            check_value("result", result, run_lit[r]);
        end
        check_value("exc", tcu_pkg::acc_t'(exc), tcu_pkg::acc_t'(want_exc));
        // Done is one cycle wide and the result holds after it
        @(negedge clk);
        check_value("done", tcu_pkg::acc_t'(done), 0);
        check_value("result", result, want_sum);
        check_value("exc", tcu_pkg::acc_t'(exc), tcu_pkg::acc_t'(want_exc));
        if (errors == err_before) begin
            $display("Test %0d %s: ok", r, run_name[r]);
        end else begin
            $display("Test %0d %s: errors", r, run_name[r]);
            tests_failed++;
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        fmt = tcu_pkg::FMT_E4M3;
        num_steps = '0;
        step_valid = 1'b0;
        a_data = '0;
        b_data = '0;
        elem_mask = '0;
        errors = 0;
        tests_failed = 0;
        n_steps = 0;
        n_runs = 0;
        rng = 32'd42;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Idle outputs right after reset
        check_value("busy", tcu_pkg::acc_t'(busy), 0);
        check_value("done", tcu_pkg::acc_t'(done), 0);
        check_value("result", result, 0);
        check_value("exc", tcu_pkg::acc_t'(exc), 0);
        if (errors == 0) begin
            $display("Test reset state: ok");
        end else begin
            $display("Test reset state: errors");
            tests_failed++;
        end
        for (int r = 0; r < n_runs; r++) begin
            run_test(r);
        end
        $display("Tests %0d, failed %0d, check errors %0d", n_runs + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
